/* ctrl_defs.svh */
// Control unit shared constants
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// RV64I major opcodes
`define OP_REG     7'b0110011 // R-type 64-bit
`define OP_REGW    7'b0111011 // R-type 32-bit
`define OP_IMM     7'b0010011 // I-type 64-bit
`define OP_IMMW    7'b0011011 // I-type 32-bit
`define OP_BRANCH  7'b1100011
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_FENCE   7'b0001111 // Decoded as NOP
`define OP_SYSTEM  7'b1110011 // ECALL, EBREAK as NOP
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111

// Field widths
`define REG_ADDR_W 5
`define ALUC_W     4
`define IMM_TYPE_W 3
`define B_TYPE_W   3

// ALU operation codes, 4'hA and 4'hC unused
`define ALU_ADD    4'h0
`define ALU_SUB    4'h1
`define ALU_AND    4'h2
`define ALU_OR     4'h3
`define ALU_XOR    4'h4
`define ALU_SLL    4'h5
`define ALU_SRL    4'h6
`define ALU_SRA    4'h7
`define ALU_ADDW   4'h8
`define ALU_SUBW   4'h9
`define ALU_LUI    4'hB
`define ALU_SLLW   4'hD
`define ALU_SRLW   4'hE
`define ALU_SRAW   4'hF

`endif

/* ctrlPkg.sv */
// Control unit types
`default_nettype none

`include "ctrl_defs.svh"

package ctrlPkg;

    // Instruction word in decode, R-type field layout
    typedef struct packed {
        logic [6:0]               funct7;
        logic [`REG_ADDR_W-1:0]   rs2;
        logic [`REG_ADDR_W-1:0]   rs1;
        logic [2:0]               funct3;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [6:0]               opcode;
    } instFieldsT;

    // EXE result mux select
    typedef enum logic [1:0] {
        RSEL_ALU     = 2'd0,
        RSEL_COMPARE = 2'd1, // SLT family
        RSEL_LINK    = 2'd2  // PC + 4 for JAL/JALR
    } rSelT;

    // Operand forwarding mux select in decode
    typedef enum logic [1:0] {
        FWD_REGFILE  = 2'd0,
        FWD_EXE_ALU  = 2'd1,
        FWD_MEM_ALU  = 2'd2,
        FWD_MEM_LOAD = 2'd3
    } fwdSelT;

    // Decode control bundle, 19 bits
    typedef struct packed {
        logic                     aSel;       // 1 selects PC
        logic                     bSel;       // 1 selects immediate
        logic [`ALUC_W-1:0]       aluc;
        rSelT                     rSel;
        logic                     wmem;       // Store enable
        logic                     m2reg;      // Write back from memory
        logic                     wreg;       // Register file write enable
        logic [`IMM_TYPE_W-1:0]   immType;
        logic [`B_TYPE_W-1:0]     bType;      // {isBranch, funct3[2], funct3[0]}
        logic                     isJal;      // JAL or JALR
        logic                     signedComp;
    } idCtrlT;

    // Hazard relevant state of one stage behind decode, 11 bits
    typedef struct packed {
        logic [`REG_ADDR_W-1:0]   rd;
        logic                     wreg;
        logic                     m2reg;
        logic [`B_TYPE_W-1:0]     bType;
        logic                     isJal;
    } stageCtrlT;

endpackage

`default_nettype wire

/* instDecoder.sv */
// Instruction decoder
`default_nettype none

`include "ctrl_defs.svh"

module instDecoder (
    input  ctrlPkg::instFieldsT inst,
    output ctrlPkg::idCtrlT     ctrl,
    output logic                rs1Used,
    output logic                rs2Used
);

    logic isBranch; // MSB of bType
    logic isCompare; // SLT, SLTU, SLTI, SLTIU

    // 64-bit ALU op from funct3, subSel and sraSel from funct7[5]
    function automatic logic [`ALUC_W-1:0] baseAluc(
        input logic [2:0] funct3,
        input logic       subSel,
        input logic       sraSel
    );
        logic [`ALUC_W-1:0] op;
        case (funct3)
            3'b000:  op = subSel ? `ALU_SUB : `ALU_ADD;
            3'b111:  op = `ALU_AND;
            3'b110:  op = `ALU_OR;
            3'b100:  op = `ALU_XOR;
            3'b001:  op = `ALU_SLL;
            3'b101:  op = sraSel ? `ALU_SRA : `ALU_SRL;
            default: op = `ALU_ADD; // Compares, ALU result unused
        endcase
        return op;
    endfunction

    // 32-bit ALU op, W variants
    function automatic logic [`ALUC_W-1:0] wordAluc(
        input logic [2:0] funct3,
        input logic       subSel,
        input logic       sraSel
    );
        logic [`ALUC_W-1:0] op;
        case (funct3)
            3'b000:  op = subSel ? `ALU_SUBW : `ALU_ADDW;
            3'b001:  op = `ALU_SLLW;
            3'b101:  op = sraSel ? `ALU_SRAW : `ALU_SRLW;
            default: op = `ALU_ADDW; // Reserved encodings
        endcase
        return op;
    endfunction

    assign isCompare = (inst.funct3[2:1] == 2'b01);

    always_comb begin
        ctrl     = '0; // NOP unless decoded below
        isBranch = 1'b0;
        rs1Used  = 1'b0;
        rs2Used  = 1'b0;
        case (inst.opcode)
            `OP_REG: begin
                ctrl.aluc       = baseAluc(inst.funct3, inst.funct7[5], inst.funct7[5]);
                ctrl.rSel       = isCompare ? ctrlPkg::RSEL_COMPARE : ctrlPkg::RSEL_ALU;
                ctrl.signedComp = isCompare & ~inst.funct3[0]; // SLT signed, SLTU not
                ctrl.wreg       = 1'b1;
                rs1Used         = 1'b1;
                rs2Used         = 1'b1;
            end
            `OP_REGW: begin
                ctrl.aluc = wordAluc(inst.funct3, inst.funct7[5], inst.funct7[5]);
                ctrl.wreg = 1'b1;
                rs1Used   = 1'b1;
                rs2Used   = 1'b1;
            end
            `OP_IMM: begin
                // No SUBI, funct7 only meaningful for shifts
                ctrl.aluc       = baseAluc(inst.funct3, 1'b0, inst.funct7[5]);
                ctrl.rSel       = isCompare ? ctrlPkg::RSEL_COMPARE : ctrlPkg::RSEL_ALU;
                ctrl.signedComp = isCompare & ~inst.funct3[0];
                ctrl.bSel       = 1'b1;
                ctrl.wreg       = 1'b1;
                ctrl.immType    = 3'h0; // I-type
                rs1Used         = 1'b1;
            end
            `OP_IMMW: begin
                ctrl.aluc    = wordAluc(inst.funct3, 1'b0, inst.funct7[5]);
                ctrl.bSel    = 1'b1; // Immediate operand
                ctrl.wreg    = 1'b1;
                ctrl.immType = 3'h0; // I-type
                rs1Used      = 1'b1;
            end
            `OP_BRANCH: begin
                ctrl.aSel       = 1'b1; // Target = PC + imm
                ctrl.bSel       = 1'b1;
                ctrl.aluc       = `ALU_ADD;
                ctrl.immType    = 3'h2; // B-type
                ctrl.signedComp = inst.funct3[2] & ~inst.funct3[1]; // BLT, BGE
                isBranch        = 1'b1;
                rs1Used         = 1'b1;
                rs2Used         = 1'b1;
            end
            `OP_LOAD: begin
                ctrl.bSel    = 1'b1; // Address = rs1 + imm
                ctrl.aluc    = `ALU_ADD;
                ctrl.m2reg   = 1'b1;
                ctrl.wreg    = 1'b1;
                ctrl.immType = 3'h0;
                rs1Used      = 1'b1;
            end
            `OP_STORE: begin
                ctrl.bSel    = 1'b1;
                ctrl.aluc    = `ALU_ADD;
                ctrl.wmem    = 1'b1;
                ctrl.immType = 3'h1;
                rs1Used      = 1'b1;
                rs2Used      = 1'b1; // Store data
            end
            `OP_LUI: begin
                ctrl.bSel    = 1'b1;
                ctrl.aluc    = `ALU_LUI; // Pass immediate
                ctrl.wreg    = 1'b1;
                ctrl.immType = 3'h3; // U-type
            end
            `OP_AUIPC: begin
                ctrl.aSel    = 1'b1;
                ctrl.bSel    = 1'b1;
                ctrl.aluc    = `ALU_ADD;
                ctrl.wreg    = 1'b1;
                ctrl.immType = 3'h3;
            end
            `OP_JAL: begin
                ctrl.aSel    = 1'b1;
                ctrl.bSel    = 1'b1;
                ctrl.aluc    = `ALU_ADD;
                ctrl.rSel    = ctrlPkg::RSEL_LINK;
                ctrl.wreg    = 1'b1;
                ctrl.immType = 3'h4; // J-type
                ctrl.isJal   = 1'b1;
            end
            `OP_JALR: begin
                ctrl.bSel    = 1'b1; // Target = rs1 + imm
                ctrl.aluc    = `ALU_ADD;
                ctrl.rSel    = ctrlPkg::RSEL_LINK;
                ctrl.wreg    = 1'b1;
                ctrl.immType = 3'h0;
                ctrl.isJal   = 1'b1;
                rs1Used      = 1'b1;
            end
            // FENCE and SYSTEM fall to the NOP defaults with unknown opcodes
            default: begin
                ctrl = '0;
            end
        endcase
        // Low bits follow funct3 for every opcode, only the MSB marks a branch
        ctrl.bType = {isBranch, inst.funct3[2], inst.funct3[0]};
    end

endmodule

`default_nettype wire

/* forwardUnit.sv */
// Operand forwarding select
`default_nettype none

module forwardUnit (
    input  ctrlPkg::instFieldsT inst,
    input  ctrlPkg::stageCtrlT  exStage,
    input  ctrlPkg::stageCtrlT  memStage,
    output ctrlPkg::fwdSelT     qaSel,
    output ctrlPkg::fwdSelT     qbSel
);

    // Select for one source register, EXE has priority over MEM
    function automatic ctrlPkg::fwdSelT pickSrc(
        input logic [4:0]         src,
        input ctrlPkg::stageCtrlT ex,
        input ctrlPkg::stageCtrlT mem
    );
        ctrlPkg::fwdSelT sel;
        logic            exHit;
        logic            memHit;
        // x0 is never forwarded
        exHit  = ex.wreg & (ex.rd != '0) & (ex.rd == src) & ~ex.m2reg; // Load data not ready
        memHit = mem.wreg & (mem.rd != '0) & (mem.rd == src);
        if (exHit) begin
            sel = ctrlPkg::FWD_EXE_ALU;
        end else if (memHit) begin
            sel = mem.m2reg ? ctrlPkg::FWD_MEM_LOAD : ctrlPkg::FWD_MEM_ALU;
        end else begin
            sel = ctrlPkg::FWD_REGFILE;
        end
        return sel;
    endfunction

    assign qaSel = pickSrc(inst.rs1, exStage, memStage); // Operand a
    assign qbSel = pickSrc(inst.rs2, exStage, memStage); // Operand b

endmodule

`default_nettype wire

/* hazardUnit.sv */
// Load-use stall and control redirect
`default_nettype none

module hazardUnit (
    input  ctrlPkg::instFieldsT inst,
    input  ctrlPkg::idCtrlT     rawCtrl,
    input  logic                rs1Used,
    input  logic                rs2Used,
    input  ctrlPkg::stageCtrlT  exStage,
    input  logic                eq,       // EXE comparator a == b
    input  logic                lt,       // EXE comparator a < b
    output ctrlPkg::idCtrlT     ctrl,
    output logic                stall,
    output logic                redirect
);

    logic srcHit;   // EXE rd matches a used source
    logic taken;    // Branch in EXE resolves taken

    assign srcHit = (rs1Used & (exStage.rd == inst.rs1))
                  | (rs2Used & (exStage.rd == inst.rs2));

    // Squashed loads have wreg cleared, so they never stall
    assign stall = exStage.wreg & exStage.m2reg & (exStage.rd != '0) & srcHit;

    always_comb begin
        case (exStage.bType)
            3'b100:  taken = eq;  // BEQ
            3'b101:  taken = ~eq; // BNE
            3'b110:  taken = lt;  // BLT, BLTU
            3'b111:  taken = ~lt; // BGE, BGEU
            default: taken = 1'b0; // Not a branch
        endcase
    end

    assign redirect = exStage.isJal | taken; // Jumps always redirect

    always_comb begin
        ctrl = rawCtrl;
        if (stall | redirect) begin
            // Kill side effects, instruction becomes a bubble in EXE
            ctrl.wreg = 1'b0;
            ctrl.wmem = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* stageTracker.sv */
// EXE and MEM control pipeline registers
`default_nettype none

`include "ctrl_defs.svh"

module stageTracker (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rd,       // Destination of decode instruction
    input  ctrlPkg::idCtrlT        idCtrl,   // Already masked by hazard unit
    input  logic                   squash,   // Stall or redirect this cycle
    output ctrlPkg::stageCtrlT     exStage,
    output ctrlPkg::stageCtrlT     memStage
);

    ctrlPkg::stageCtrlT nextEx; // Decode fields entering EXE

    always_comb begin
        nextEx.rd    = rd;
        nextEx.wreg  = idCtrl.wreg;
        nextEx.m2reg = idCtrl.m2reg;
        // Squashed branch or jump must not redirect from EXE
        nextEx.bType = squash ? '0 : idCtrl.bType;
        nextEx.isJal = squash ? 1'b0 : idCtrl.isJal;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exStage  <= '0; // Bubbles
            memStage <= '0;
        end else begin
            exStage  <= nextEx;
            memStage <= exStage; // Advance one stage
        end
    end

endmodule

`default_nettype wire

/* controlUnit.sv */
// Decode stage control unit
`default_nettype none

module controlUnit (
    input  logic                clk,
    input  logic                rstN,
    input  ctrlPkg::instFieldsT inst,      // Instruction in decode
    input  logic                eq,        // EXE comparator flags
    input  logic                lt,
    output ctrlPkg::idCtrlT     idCtrl,
    output ctrlPkg::fwdSelT     qaSel,
    output ctrlPkg::fwdSelT     qbSel,
    output logic                pcStall,
    output logic                ifidStall,
    output logic                redirect   // PC to target, decode becomes NOP
);

    ctrlPkg::idCtrlT    rawCtrl;  // Decoder output before hazard masking
    ctrlPkg::stageCtrlT exStage;
    ctrlPkg::stageCtrlT memStage;
    logic               rs1Used;
    logic               rs2Used;
    logic               stall;    // Load-use

    instDecoder uDecoder (
        .inst    (inst),
        .ctrl    (rawCtrl),
        .rs1Used (rs1Used),
        .rs2Used (rs2Used)
    );

    forwardUnit uForward (
        .inst     (inst),
        .exStage  (exStage),
        .memStage (memStage),
        .qaSel    (qaSel),
        .qbSel    (qbSel)
    );

    hazardUnit uHazard (
        .inst     (inst),
        .rawCtrl  (rawCtrl),
        .rs1Used  (rs1Used),
        .rs2Used  (rs2Used),
        .exStage  (exStage),
        .eq       (eq),
        .lt       (lt),
        .ctrl     (idCtrl),
        .stall    (stall),
        .redirect (redirect)
    );

    stageTracker uTracker (
        .clk      (clk),
        .rstN     (rstN),
        .rd       (inst.rd),
        .idCtrl   (idCtrl),
        .squash   (stall | redirect),
        .exStage  (exStage),
        .memStage (memStage)
    );

    // PC and IF/ID hold together
    assign pcStall   = stall;
    assign ifidStall = stall;

endmodule

`default_nettype wire

/* controlUnitTb.sv */
// Control unit testbench
`default_nettype none

`include "ctrl_defs.svh"

module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numRand  = 2000;
    localparam int numSteps = numRand + 60; // Random plus directed steps

    logic                clk;
    logic                rstN;
    ctrlPkg::instFieldsT inst;
    logic                eq;
    logic                lt;
    ctrlPkg::idCtrlT     idCtrl;
    ctrlPkg::fwdSelT     qaSel;
    ctrlPkg::fwdSelT     qbSel;
    logic                pcStall;
    logic                ifidStall;
    logic                redirect;

    ctrlPkg::stageCtrlT mEx;  // Model EXE stage
    ctrlPkg::stageCtrlT mMem; // Model MEM stage
    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;

    controlUnit dut (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (inst),
        .eq        (eq),
        .lt        (lt),
        .idCtrl    (idCtrl),
        .qaSel     (qaSel),
        .qbSel     (qbSel),
        .pcStall   (pcStall),
        .ifidStall (ifidStall),
        .redirect  (redirect)
    );

    always #50 clk = ~clk; // 100 ns period

    // One bit per step, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic ctrlPkg::instFieldsT mk(input logic [6:0] op, input logic [4:0] rd,
            input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // ALU code table, sub for register SUB, arith for SRA shifts
    function automatic logic [3:0] aluFor(input logic w, input logic [2:0] f3,
            input logic sub, input logic arith);
        case (f3)
            3'b000:  return w ? (sub ? `ALU_SUBW : `ALU_ADDW) : (sub ? `ALU_SUB : `ALU_ADD);
            3'b001:  return w ? `ALU_SLLW : `ALU_SLL;
            3'b101:  return w ? (arith ? `ALU_SRAW : `ALU_SRLW) : (arith ? `ALU_SRA : `ALU_SRL);
            3'b111:  return w ? `ALU_ADDW : `ALU_AND;
            3'b110:  return w ? `ALU_ADDW : `ALU_OR;
            3'b100:  return w ? `ALU_ADDW : `ALU_XOR;
            default: return w ? `ALU_ADDW : `ALU_ADD; // Compares
        endcase
    endfunction

    // Reference decode from the control table
    function automatic void refDecode(input ctrlPkg::instFieldsT i,
            output ctrlPkg::idCtrlT c, output logic u1, output logic u2);
        logic cmp;
        logic w;
        logic isReg;
        c     = '0;
        u1    = 1'b0;
        u2    = 1'b0;
        cmp   = (i.funct3 == 3'b010) || (i.funct3 == 3'b011);
        w     = (i.opcode == `OP_REGW) || (i.opcode == `OP_IMMW);
        isReg = (i.opcode == `OP_REG) || (i.opcode == `OP_REGW);
        case (i.opcode)
            `OP_REG, `OP_REGW, `OP_IMM, `OP_IMMW: begin
                c.wreg    = 1'b1;
                c.bSel    = ~isReg;
                c.aluc    = aluFor(w, i.funct3, isReg & i.funct7[5], i.funct7[5]);
                u1        = 1'b1;
                u2        = isReg;
                if (!w && cmp) begin
                    c.rSel       = ctrlPkg::RSEL_COMPARE;
                    c.signedComp = (i.funct3 == 3'b010); // SLT, SLTI
                end
            end
            `OP_BRANCH: begin
                c.aSel       = 1'b1;
                c.bSel       = 1'b1;
                c.immType    = 3'h2;
                c.signedComp = (i.funct3 == 3'b100) || (i.funct3 == 3'b101);
                u1           = 1'b1;
                u2           = 1'b1;
            end
            `OP_LOAD: begin
                c.bSel  = 1'b1;
                c.m2reg = 1'b1;
                c.wreg  = 1'b1;
                u1      = 1'b1;
            end
            `OP_STORE: begin
                c.bSel    = 1'b1;
                c.wmem    = 1'b1;
                c.immType = 3'h1;
                u1        = 1'b1;
                u2        = 1'b1;
            end
            `OP_LUI: begin
                c.bSel    = 1'b1;
                c.wreg    = 1'b1;
                c.aluc    = `ALU_LUI;
                c.immType = 3'h3;
            end
            `OP_AUIPC: begin
                c.aSel    = 1'b1;
                c.bSel    = 1'b1;
                c.wreg    = 1'b1;
                c.immType = 3'h3;
            end
            `OP_JAL, `OP_JALR: begin
                c.aSel    = (i.opcode == `OP_JAL); // JALR targets rs1 + imm
                c.bSel    = 1'b1;
                c.rSel    = ctrlPkg::RSEL_LINK;
                c.wreg    = 1'b1;
                c.immType = (i.opcode == `OP_JAL) ? 3'h4 : 3'h0;
                c.isJal   = 1'b1;
                u1        = (i.opcode == `OP_JALR);
            end
            default: c = '0; // FENCE, SYSTEM, unknown
        endcase
        c.bType = {i.opcode == `OP_BRANCH, i.funct3[2], i.funct3[0]};
    endfunction

    // EXE over MEM, no forwarding of x0 or of a load still in EXE
    function automatic ctrlPkg::fwdSelT fwdFor(input logic [4:0] src);
        if (mEx.wreg && mEx.rd != 0 && mEx.rd == src && !mEx.m2reg) begin
            return ctrlPkg::FWD_EXE_ALU;
        end else if (mMem.wreg && mMem.rd != 0 && mMem.rd == src) begin
            return mMem.m2reg ? ctrlPkg::FWD_MEM_LOAD : ctrlPkg::FWD_MEM_ALU;
        end
        return ctrlPkg::FWD_REGFILE;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAIL %0d ns %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // Drive one decode cycle, check all outputs, advance the model
    task automatic step(input ctrlPkg::instFieldsT i, input logic e, input logic l);
        ctrlPkg::idCtrlT c;
        logic            u1;
        logic            u2;
        logic            st;
        logic            tk;
        logic            rdr;
        @(posedge clk);
        inst <= i;
        eq   <= e;
        lt   <= l;
        @(negedge clk); // Outputs settled
        refDecode(i, c, u1, u2);
        st = mEx.wreg && mEx.m2reg && mEx.rd != 0
           && ((u1 && mEx.rd == i.rs1) || (u2 && mEx.rd == i.rs2));
        case (mEx.bType)
            3'b100:  tk = e;
            3'b101:  tk = ~e;
            3'b110:  tk = l;
            3'b111:  tk = ~l;
            default: tk = 1'b0;
        endcase
        rdr = mEx.isJal | tk;
        if (st || rdr) begin
            c.wreg = 1'b0; // Squashed into a bubble
            c.wmem = 1'b0;
        end
        checkVal("idCtrl", c, idCtrl);
        checkVal("qaSel", fwdFor(i.rs1), qaSel);
        checkVal("qbSel", fwdFor(i.rs2), qbSel);
        checkVal("pcStall", st, pcStall);
        checkVal("ifidStall", st, ifidStall);
        checkVal("redirect", rdr, redirect);
        mMem        = mEx;
        mEx.rd      = i.rd;
        mEx.wreg    = c.wreg;
        mEx.m2reg   = c.m2reg;
        mEx.bType   = (st || rdr) ? 3'b000 : c.bType;
        mEx.isJal   = (st || rdr) ? 1'b0 : c.isJal;
    endtask

    initial begin
        #((numSteps + 20) * 100ns + 10us);
        $display("Timeout: the run did not finish in the expected time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [6:0]          opList [13];
        ctrlPkg::instFieldsT nop;
        ctrlPkg::instFieldsT ri;
        logic [6:0]          rOp;
        logic [4:0]          rRd;
        logic [2:0]          rF3;
        logic [4:0]          rRs1;
        logic [4:0]          rRs2;
        logic                rF7b;
        logic                rEq;
        logic                rLt;
        opList = '{`OP_REG, `OP_REGW, `OP_IMM, `OP_IMMW, `OP_BRANCH, `OP_LOAD, `OP_STORE,
                   `OP_FENCE, `OP_SYSTEM, `OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR};
        nop    = 32'h0000_0013; // ADDI x0, x0, 0
        lfsr   = 32'hc365_9e79;
        errors = 0;
        checks = 0;
        clk    = 1'b0;
        rstN   = 1'b0;
        inst   = nop;
        eq     = 1'b0;
        lt     = 1'b0;
        mEx    = '0;
        mMem   = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        step(nop, 1'b0, 1'b0); // Check 1, quiet after reset
        // Check 2, table fields
        step(mk(`OP_REG, 5'd1, 3'b000, 5'd2, 5'd3, 7'h00), 1'b0, 1'b0);
        checkVal("aluc ADD", `ALU_ADD, idCtrl.aluc);
        step(mk(`OP_REG, 5'd1, 3'b000, 5'd2, 5'd3, 7'h20), 1'b0, 1'b0);
        checkVal("aluc SUB", `ALU_SUB, idCtrl.aluc);
        step(mk(`OP_REGW, 5'd1, 3'b101, 5'd2, 5'd3, 7'h20), 1'b0, 1'b0);
        checkVal("aluc SRAW", `ALU_SRAW, idCtrl.aluc);
        step(mk(`OP_IMM, 5'd1, 3'b011, 5'd2, 5'd3, 7'h00), 1'b0, 1'b0);
        checkVal("rSel SLTIU", ctrlPkg::RSEL_COMPARE, idCtrl.rSel);
        checkVal("signedComp SLTIU", 1'b0, idCtrl.signedComp);
        checkVal("bSel SLTIU", 1'b1, idCtrl.bSel);
        step(mk(`OP_LOAD, 5'd9, 3'b011, 5'd2, 5'd0, 7'h00), 1'b0, 1'b0);
        checkVal("m2reg load", 1'b1, idCtrl.m2reg);
        step(mk(`OP_STORE, 5'd0, 3'b011, 5'd2, 5'd3, 7'h00), 1'b0, 1'b0);
        checkVal("wmem store", 1'b1, idCtrl.wmem);
        checkVal("immType store", 3'h1, idCtrl.immType);
        step(mk(`OP_LUI, 5'd4, 3'b000, 5'd0, 5'd0, 7'h00), 1'b0, 1'b0);
        checkVal("aluc LUI", `ALU_LUI, idCtrl.aluc);
        step(mk(`OP_JALR, 5'd1, 3'b000, 5'd2, 5'd0, 7'h00), 1'b0, 1'b0);
        checkVal("rSel JALR", ctrlPkg::RSEL_LINK, idCtrl.rSel);
        step(nop, 1'b0, 1'b0); // Jump redirects here
        checkVal("redirect JALR", 1'b1, redirect);
        step(mk(`OP_BRANCH, 5'd0, 3'b100, 5'd1, 5'd2, 7'h00), 1'b0, 1'b0);
        checkVal("bType BLT", 3'b110, idCtrl.bType);
        checkVal("signedComp BLT", 1'b1, idCtrl.signedComp);
        // Check 3, forwarding priority
        step(mk(`OP_REG, 5'd5, 3'b000, 5'd1, 5'd2, 7'h00), 1'b0, 1'b0);
        step(mk(`OP_REG, 5'd5, 3'b000, 5'd1, 5'd2, 7'h00), 1'b0, 1'b0);
        step(mk(`OP_REG, 5'd6, 3'b000, 5'd5, 5'd0, 7'h00), 1'b0, 1'b0);
        checkVal("qaSel EXE first", ctrlPkg::FWD_EXE_ALU, qaSel);
        step(mk(`OP_REG, 5'd0, 3'b000, 5'd1, 5'd2, 7'h00), 1'b0, 1'b0); // Writes x0
        step(mk(`OP_REG, 5'd6, 3'b000, 5'd0, 5'd0, 7'h00), 1'b0, 1'b0);
        checkVal("qaSel x0", ctrlPkg::FWD_REGFILE, qaSel);
        checkVal("qbSel x0", ctrlPkg::FWD_REGFILE, qbSel);
        step(mk(`OP_LOAD, 5'd7, 3'b011, 5'd1, 5'd0, 7'h00), 1'b0, 1'b0);
        step(nop, 1'b0, 1'b0);
        step(mk(`OP_REG, 5'd6, 3'b000, 5'd1, 5'd7, 7'h00), 1'b0, 1'b0);
        checkVal("qbSel MEM load", ctrlPkg::FWD_MEM_LOAD, qbSel);
        // Check 4, load-use stall and immediate rs2 field
        step(mk(`OP_LOAD, 5'd8, 3'b011, 5'd1, 5'd0, 7'h00), 1'b0, 1'b0);
        step(mk(`OP_REG, 5'd6, 3'b000, 5'd8, 5'd2, 7'h00), 1'b0, 1'b0);
        checkVal("pcStall load-use", 1'b1, pcStall);
        checkVal("wreg stalled", 1'b0, idCtrl.wreg);
        step(mk(`OP_REG, 5'd6, 3'b000, 5'd8, 5'd2, 7'h00), 1'b0, 1'b0);
        checkVal("pcStall released", 1'b0, pcStall);
        step(mk(`OP_LOAD, 5'd8, 3'b011, 5'd1, 5'd0, 7'h00), 1'b0, 1'b0);
        step(mk(`OP_IMM, 5'd6, 3'b000, 5'd1, 5'd8, 7'h00), 1'b0, 1'b0);
        checkVal("pcStall imm rs2", 1'b0, pcStall);
        step(mk(`OP_LOAD, 5'd8, 3'b011, 5'd1, 5'd0, 7'h00), 1'b0, 1'b0);
        step(mk(`OP_STORE, 5'd0, 3'b011, 5'd1, 5'd8, 7'h00), 1'b0, 1'b0); // Store data
        checkVal("wmem stalled", 1'b0, idCtrl.wmem);
        // Check 5, every branch type both ways, then JAL
        for (int b = 0; b < 8; b++) begin
            step(mk(`OP_BRANCH, 5'd0, {b[1], 1'b0, b[0]}, 5'd1, 5'd2, 7'h00), 1'b0, 1'b0);
            step(mk(`OP_STORE, 5'd0, 3'b011, 5'd1, 5'd2, 7'h00), b[2], b[2]);
            step(nop, 1'b0, 1'b0);
        end
        step(mk(`OP_JAL, 5'd1, 3'b000, 5'd0, 5'd0, 7'h00), 1'b0, 1'b0);
        step(mk(`OP_BRANCH, 5'd0, 3'b000, 5'd1, 5'd1, 7'h00), 1'b0, 1'b0);
        checkVal("redirect JAL", 1'b1, redirect);
        step(nop, 1'b1, 1'b0);
        checkVal("redirect squashed", 1'b0, redirect);
        // Check 6, random stream, small register range for more hazards
        for (int n = 0; n < numRand; n++) begin
            rOp  = opList[randBits(4) % 13];
            rRd  = 5'(randBits(3));
            rF3  = 3'(randBits(3));
            rRs1 = 5'(randBits(3));
            rRs2 = 5'(randBits(3));
            rF7b = (randBits(1) != 0); // funct7[5], SUB and SRA
            rEq  = (randBits(1) != 0);
            rLt  = (randBits(1) != 0);
            ri   = mk(rOp, rRd, rF3, rRs1, rRs2, {1'b0, rF7b, 5'b0});
            step(ri, rEq, rLt);
        end
        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
ctrlPkg.sv
instDecoder.sv
forwardUnit.sv
hazardUnit.sv
stageTracker.sv
controlUnit.sv
controlUnitTb.sv

/* Bender.yml */
package:
  name: controlUnit

export_include_dirs:
  - .

sources:
  - files:
      - ctrlPkg.sv
      - instDecoder.sv
      - forwardUnit.sv
      - hazardUnit.sv
      - stageTracker.sv
      - controlUnit.sv
  - target: test
    files:
      - controlUnitTb.sv
